// File: common/cache_pkg.sv
package cache_pkg;

    // ----------------------------------------
    // geometry
    // ----------------------------------------
    localparam int TAG_WIDTH  = 10;
    localparam int SET_WIDTH  = 4;
    localparam int DATA_WIDTH = 32;
    localparam int NUM_SETS   = 1 << SET_WIDTH;  // direct mapped, one line per set

    typedef logic [TAG_WIDTH-1:0]  tag_t;
    typedef logic [SET_WIDTH-1:0]  set_t;
    typedef logic [DATA_WIDTH-1:0] line_data_t;  // one word per line

    // ----------------------------------------
    // line storage
    // ----------------------------------------
    typedef struct packed {
        logic       valid;
        tag_t       tag;
        line_data_t data;
    } cache_line_t;

    // line plus home set, kept together while it sits in the victim buffer
    typedef struct packed {
        cache_line_t line;
        set_t        set;
    } victim_entry_t;

endpackage

// File: common/mem_pkg.sv
package mem_pkg;

    import cache_pkg::*;

    localparam int ADDR_WIDTH = TAG_WIDTH + SET_WIDTH;

    typedef logic [ADDR_WIDTH-1:0] addr_t;  // {tag, set}

    typedef enum logic {
        op_lookup,
        op_fill
    } cache_op_t;

    typedef enum logic [1:0] {
        src_miss,
        src_store,
        src_victim
    } resp_src_t;

    // ----------------------------------------
    // client and memory side records
    // ----------------------------------------
    typedef struct packed {
        logic       valid;
        cache_op_t  op;
        addr_t      addr;
        line_data_t data;  // fill only
    } cache_req_t;

    typedef struct packed {
        logic       valid;
        resp_src_t  src;
        addr_t      addr;
        line_data_t data;
    } cache_resp_t;

    typedef struct packed {
        logic       valid;
        addr_t      addr;
        line_data_t data;
    } wb_req_t;

    function automatic tag_t addr_tag(addr_t addr);
        return addr[ADDR_WIDTH-1:SET_WIDTH];
    endfunction

    function automatic set_t addr_set(addr_t addr);
        return addr[SET_WIDTH-1:0];
    endfunction

    function automatic addr_t make_addr(tag_t tag, set_t set);
        return {tag, set};
    endfunction

endpackage

// File: design/cache_top.sv
`timescale 1ns/1ps

module cache_top
    import cache_pkg::*;
    import mem_pkg::*;
#(
    parameter int VICTIM_DEPTH = 4
) (
    input  logic        clock,
    input  logic        reset,
    input  cache_req_t  req,
    output cache_resp_t resp,
    output wb_req_t     wb
);

    // store <-> victim buffer
    logic          probe_valid;
    tag_t          probe_tag;
    set_t          probe_set;
    logic          probe_hit;
    cache_line_t   probe_line;
    logic          push_valid;
    victim_entry_t push_entry;

    // to response unit
    logic          look_valid;
    resp_src_t     look_src;
    addr_t         look_addr;
    line_data_t    look_data;
    logic          fired_valid;
    victim_entry_t fired_entry;

    l1_tag_store i_tag_store (
        .clock       (clock),
        .reset       (reset),
        .req         (req),
        .probe_valid (probe_valid),
        .probe_tag   (probe_tag),
        .probe_set   (probe_set),
        .probe_hit   (probe_hit),
        .probe_line  (probe_line),
        .push_valid  (push_valid),
        .push_entry  (push_entry),
        .look_valid  (look_valid),
        .look_src    (look_src),
        .look_addr   (look_addr),
        .look_data   (look_data)
    );

    victim_buffer #(
        .VICTIM_DEPTH (VICTIM_DEPTH)
    ) i_victim_buffer (
        .clock       (clock),
        .reset       (reset),
        .push_valid  (push_valid),
        .push_entry  (push_entry),
        .probe_valid (probe_valid),
        .probe_tag   (probe_tag),
        .probe_set   (probe_set),
        .probe_hit   (probe_hit),
        .probe_line  (probe_line),
        .fired_valid (fired_valid),
        .fired_entry (fired_entry)
    );

    response_unit i_response_unit (
        .clock       (clock),
        .reset       (reset),
        .look_valid  (look_valid),
        .look_src    (look_src),
        .look_addr   (look_addr),
        .look_data   (look_data),
        .fired_valid (fired_valid),
        .fired_entry (fired_entry),
        .resp        (resp),
        .wb          (wb)
    );

endmodule

// File: design/l1_tag_store.sv
`timescale 1ns/1ps

module l1_tag_store
    import cache_pkg::*;
    import mem_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  cache_req_t    req,
    output logic          probe_valid,
    output tag_t          probe_tag,
    output set_t          probe_set,
    input  logic          probe_hit,
    input  cache_line_t   probe_line,
    output logic          push_valid,
    output victim_entry_t push_entry,
    output logic          look_valid,
    output resp_src_t     look_src,
    output addr_t         look_addr,
    output line_data_t    look_data
);

    cache_line_t lines [NUM_SETS];

    tag_t        req_tag;
    set_t        req_set;
    cache_line_t cur_line;
    logic        is_lookup;
    logic        is_fill;
    logic        store_hit;
    logic        swap_in;
    logic        write_en;
    cache_line_t write_line;

    // ----------------------------------------
    // request decode
    // ----------------------------------------
    assign req_tag   = addr_tag(req.addr);
    assign req_set   = addr_set(req.addr);
    assign cur_line  = lines[req_set];
    assign is_lookup = req.valid && (req.op == op_lookup);
    assign is_fill   = req.valid && (req.op == op_fill);
    assign store_hit = cur_line.valid && (cur_line.tag == req_tag);

    // ----------------------------------------
    // victim probe and eviction
    // ----------------------------------------
    assign probe_valid = is_lookup && !store_hit;  // only on a store miss
    assign probe_tag   = req_tag;
    assign probe_set   = req_set;
    assign swap_in     = probe_valid && probe_hit;

    // old line leaves on a fill or on a swap back from the buffer
    assign push_valid = (is_fill || swap_in) && cur_line.valid;
    assign push_entry = '{line: cur_line, set: req_set};

    assign write_en = is_fill || swap_in;

    always_comb begin
        if (is_fill) begin
            write_line = '{valid: 1'b1, tag: req_tag, data: req.data};
        end else begin
            write_line = probe_line;  // reclaimed from the buffer
        end
    end

    // ----------------------------------------
    // lookup result
    // ----------------------------------------
    assign look_valid = is_lookup;
    assign look_addr  = req.addr;

    always_comb begin
        if (store_hit) begin
            look_src  = src_store;
            look_data = cur_line.data;
        end else if (swap_in) begin
            look_src  = src_victim;
            look_data = probe_line.data;
        end else begin
            look_src  = src_miss;
            look_data = '0;
        end
    end

    // ----------------------------------------
    // line array
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                lines[i].valid <= 1'b0;
            end
        end else if (write_en) begin
            lines[req_set] <= write_line;
        end
    end

    // a line taken back from the buffer must be the one that was probed
    a_swap_line_matches: assert property (
        @(posedge clock) disable iff (reset)
        swap_in |-> (probe_line.valid && (probe_line.tag == probe_tag))
    ) else $error("reclaimed line does not match the probed tag");

endmodule

// File: design/response_unit.sv
`timescale 1ns/1ps

module response_unit
    import cache_pkg::*;
    import mem_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          look_valid,
    input  resp_src_t     look_src,
    input  addr_t         look_addr,
    input  line_data_t    look_data,
    input  logic          fired_valid,
    input  victim_entry_t fired_entry,
    output cache_resp_t   resp,
    output wb_req_t       wb
);

    logic       resp_valid_q;
    resp_src_t  resp_src_q;
    addr_t      resp_addr_q;
    line_data_t resp_data_q;

    // ----------------------------------------
    // lookup response, one cycle after the request
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= look_valid;
        end
    end

    always_ff @(posedge clock) begin
        resp_src_q  <= look_src;
        resp_addr_q <= look_addr;
        resp_data_q <= look_data;
    end

    assign resp = '{
        valid: resp_valid_q,
        src:   resp_src_q,
        addr:  resp_addr_q,
        data:  resp_data_q
    };

    // ----------------------------------------
    // writeback
    // ----------------------------------------
    // fired_* are already registers in the buffer
    assign wb = '{
        valid: fired_valid,
        addr:  make_addr(fired_entry.line.tag, fired_entry.set),  // home address
        data:  fired_entry.line.data
    };

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=cache_top_tb

verilator --binary --timing --assert \
    --top-module "$TOP" \
    -f sources.f \
    --Mdir "$BUILD_DIR" \
    -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see $LOG"
exit 1

// File: sources.f
common/cache_pkg.sv
common/mem_pkg.sv
victim_buffer/match_cam.sv
victim_buffer/victim_buffer.sv
design/l1_tag_store.sv
design/response_unit.sv
design/cache_top.sv
verification/cache_top_tb.sv

// File: verification/cache_top_tb.sv
`timescale 1ns/1ps

module cache_top_tb
    import cache_pkg::*;
    import mem_pkg::*;
();

    localparam int VICTIM_DEPTH   = 4;
    localparam int LAST           = VICTIM_DEPTH - 1;
    localparam int WB_LATENCY     = VICTIM_DEPTH + 1;  // slots plus the fire register
    localparam int RESET_CYCLES   = 2;
    localparam int DIRECTED_BOUND = 25;                // per directed test, waits included
    localparam int RANDOM_OPS     = 400;
    localparam int CYCLE_LIMIT    = RESET_CYCLES + 4 * DIRECTED_BOUND + RANDOM_OPS
                                    + (WB_LATENCY + 1) + 10;

    logic        clock;
    logic        reset;
    cache_req_t  req;
    cache_resp_t resp;
    wb_req_t     wb;

    cache_top #(
        .VICTIM_DEPTH (VICTIM_DEPTH)
    ) i_cache_top (
        .clock (clock),
        .reset (reset),
        .req   (req),
        .resp  (resp),
        .wb    (wb)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    // ----------------------------------------
    // reference model state
    // ----------------------------------------
    cache_line_t   m_lines [NUM_SETS];
    victim_entry_t m_slots [VICTIM_DEPTH];
    logic          exp_resp_valid;
    resp_src_t     exp_resp_src;
    addr_t         exp_resp_addr;
    line_data_t    exp_resp_data;
    logic          exp_wb_valid;
    addr_t         exp_wb_addr;
    line_data_t    exp_wb_data;

    string       test_name;
    int          test_errors  = 0;
    int          total_errors = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          cycle_count  = 0;
    logic [31:0] lfsr         = 32'd68778;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr  = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic report_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
        test_errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("[%s] %s", test_name, msg);
        test_errors++;
    endtask

    // advance the model by one request and predict the outputs after the edge
    task automatic model_step(input cache_req_t r);
        tag_t          t;
        set_t          s;
        victim_entry_t kept [VICTIM_DEPTH];
        victim_entry_t push;
        logic          push_v;
        int            hit;
        t      = r.addr[13:4];
        s      = r.addr[3:0];
        kept   = m_slots;
        push   = '{line: m_lines[s], set: s};
        push_v = 1'b0;
        hit    = -1;
        exp_resp_valid = r.valid && (r.op == op_lookup);
        exp_resp_src   = src_miss;
        exp_resp_addr  = r.addr;
        exp_resp_data  = '0;
        if (r.valid && r.op == op_fill) begin
            push_v     = m_lines[s].valid;
            m_lines[s] = '{valid: 1'b1, tag: t, data: r.data};
        end else if (exp_resp_valid) begin
            if (m_lines[s].valid && m_lines[s].tag == t) begin
                exp_resp_src  = src_store;
                exp_resp_data = m_lines[s].data;
            end else begin
                for (int i = LAST; i >= 0; i--) begin
                    if (kept[i].line.valid && kept[i].line.tag == t && kept[i].set == s) begin
                        hit = i;  // lowest slot wins
                    end
                end
                if (hit >= 0) begin
                    exp_resp_src           = src_victim;
                    exp_resp_data          = kept[hit].line.data;
                    push_v                 = m_lines[s].valid;
                    m_lines[s]             = kept[hit].line;
                    kept[hit].line.valid   = 1'b0;
                end
            end
        end
        exp_wb_valid = kept[LAST].line.valid;
        exp_wb_addr  = {kept[LAST].line.tag, kept[LAST].set};
        exp_wb_data  = kept[LAST].line.data;
        for (int i = LAST; i > 0; i--) begin
            m_slots[i] = kept[i-1];
        end
        m_slots[0]            = push;
        m_slots[0].line.valid = push_v;
    endtask

    task automatic compare_outputs();
        if (resp.valid !== exp_resp_valid) begin
            report_value("resp.valid", 32'(exp_resp_valid), 32'(resp.valid));
        end else if (exp_resp_valid) begin
            if (resp.src != exp_resp_src) begin
                report_value("resp.src", 32'(exp_resp_src), 32'(resp.src));
            end
            if (resp.addr != exp_resp_addr) begin
                report_value("resp.addr", 32'(exp_resp_addr), 32'(resp.addr));
            end
            if (exp_resp_src != src_miss && resp.data != exp_resp_data) begin
                report_value("resp.data", exp_resp_data, resp.data);
            end
        end
        if (wb.valid !== exp_wb_valid) begin
            report_value("wb.valid", 32'(exp_wb_valid), 32'(wb.valid));
        end else if (exp_wb_valid) begin
            if (wb.addr != exp_wb_addr) begin
                report_value("wb.addr", 32'(exp_wb_addr), 32'(wb.addr));
            end
            if (wb.data != exp_wb_data) begin
                report_value("wb.data", exp_wb_data, wb.data);
            end
        end
    endtask

    // ----------------------------------------
    // cycle engine
    // ----------------------------------------
    task automatic tick();
        @(posedge clock);
        #1;
        compare_outputs();
    endtask

    task automatic apply(input cache_req_t r);
        req = r;
        model_step(r);
    endtask

    task automatic issue(input cache_op_t op, input addr_t addr, input line_data_t data);
        apply('{valid: 1'b1, op: op, addr: addr, data: data});
        tick();
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            apply('0);
            tick();
        end
    endtask

    task automatic check_resp(input resp_src_t src, input line_data_t data);
        if (!resp.valid) begin
            report_problem("no response in the cycle after the lookup");
        end else begin
            if (resp.src != src) begin
                report_value("resp.src", 32'(src), 32'(resp.src));
            end
            if (src != src_miss && resp.data != data) begin
                report_value("resp.data", data, resp.data);
            end
        end
    endtask

    task automatic wait_for_wb(input int already, output int waited);
        waited = already;
        while (!wb.valid && waited < WB_LATENCY + 3) begin
            idle(1);
            waited++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        idle(WB_LATENCY + 1);  // let pending victims drain
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    // ----------------------------------------
    // tests
    // ----------------------------------------
    initial begin
        int          waited;
        logic [31:0] bits;
        addr_t       addr;
        reset = 1'b1;
        req   = '0;
        for (int i = 0; i < NUM_SETS; i++) begin
            m_lines[i] = '0;
        end
        for (int i = 0; i < VICTIM_DEPTH; i++) begin
            m_slots[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;

        start_test("store_hit");
        issue(op_fill, {10'h011, 4'h1}, 32'ha5a5_0001);
        issue(op_lookup, {10'h011, 4'h1}, '0);
        check_resp(src_store, 32'ha5a5_0001);
        finish_test();

        start_test("cold_miss");
        issue(op_lookup, {10'h022, 4'h2}, '0);
        check_resp(src_miss, '0);
        issue(op_fill, {10'h022, 4'h2}, 32'h0000_2222);
        issue(op_lookup, {10'h023, 4'h2}, '0);  // same set, other tag
        check_resp(src_miss, '0);
        finish_test();

        start_test("victim_reclaim");
        issue(op_fill, {10'h031, 4'h3}, 32'hdead_0031);
        issue(op_fill, {10'h032, 4'h3}, 32'hbeef_0032);
        idle(1);
        issue(op_lookup, {10'h031, 4'h3}, '0);
        check_resp(src_victim, 32'hdead_0031);
        issue(op_lookup, {10'h031, 4'h3}, '0);
        check_resp(src_store, 32'hdead_0031);
        wait_for_wb(2, waited);
        if (!wb.valid) begin
            report_problem("evicted line B never reached the writeback port");
        end else if (wb.addr != {10'h032, 4'h3}) begin
            report_value("wb.addr", 32'({10'h032, 4'h3}), 32'(wb.addr));
        end
        finish_test();

        start_test("writeback_timing");
        issue(op_fill, {10'h051, 4'h5}, 32'h1234_0051);
        issue(op_fill, {10'h052, 4'h5}, 32'h1234_0052);
        wait_for_wb(1, waited);
        if (!wb.valid) begin
            report_problem("evicted line never reached the writeback port");
        end else begin
            if (waited != WB_LATENCY) begin
                report_value("wb latency", WB_LATENCY, waited);
            end
            if (wb.addr != {10'h051, 4'h5}) begin
                report_value("wb.addr", 32'({10'h051, 4'h5}), 32'(wb.addr));
            end
            if (wb.data != 32'h1234_0051) begin
                report_value("wb.data", 32'h1234_0051, wb.data);
            end
        end
        issue(op_fill, {10'h053, 4'h5}, 32'h1234_0053);
        issue(op_lookup, {10'h052, 4'h5}, '0);  // takes the line back from the buffer
        repeat (WB_LATENCY + 2) begin
            idle(1);
            if (wb.valid && wb.addr == {10'h052, 4'h5}) begin
                report_problem("reclaimed line was written back");
            end
        end
        finish_test();

        start_test("random_mix");
        for (int k = 0; k < RANDOM_OPS; k++) begin
            bits = take_bits(2);
            if (bits[1:0] == 2'b00) begin
                idle(1);
            end else begin
                bits = take_bits(6);
                addr = {8'h40, bits[1:0], 1'b0, bits[4:2]};  // 4 tags over 8 sets
                if (bits[5]) begin
                    issue(op_fill, addr, take_bits(32));
                end else begin
                    issue(op_lookup, addr, '0);
                end
            end
        end
        finish_test();

        $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: victim_buffer/match_cam.sv
`timescale 1ns/1ps

module match_cam #(
    parameter int ENTRIES   = 4,
    parameter int KEY_WIDTH = 8
) (
    input  logic [KEY_WIDTH-1:0]              key,
    input  logic [ENTRIES-1:0][KEY_WIDTH-1:0] table_keys,
    output logic [ENTRIES-1:0]                hits
);

    // ----------------------------------------
    // one comparator per entry
    // ----------------------------------------
    // no valid qualification here, the caller masks with its busy bits
    genvar i;
    generate
        for (i = 0; i < ENTRIES; i++) begin : g_cmp
            assign hits[i] = (table_keys[i] == key);
        end
    endgenerate

endmodule

// File: victim_buffer/victim_buffer.sv
`timescale 1ns/1ps

module victim_buffer
    import cache_pkg::*;
#(
    parameter int VICTIM_DEPTH = 4
) (
    input  logic          clock,
    input  logic          reset,
    input  logic          push_valid,
    input  victim_entry_t push_entry,
    input  logic          probe_valid,
    input  tag_t          probe_tag,
    input  set_t          probe_set,
    output logic          probe_hit,
    output cache_line_t   probe_line,
    output logic          fired_valid,
    output victim_entry_t fired_entry
);

    localparam int IDX_WIDTH = (VICTIM_DEPTH > 1) ? $clog2(VICTIM_DEPTH) : 1;
    localparam int LAST      = VICTIM_DEPTH - 1;

    victim_entry_t [VICTIM_DEPTH-1:0] slots;
    victim_entry_t [VICTIM_DEPTH-1:0] kept;
    victim_entry_t [VICTIM_DEPTH-1:0] slots_next;

    tag_t [VICTIM_DEPTH-1:0] slot_tags;
    set_t [VICTIM_DEPTH-1:0] slot_sets;
    logic [VICTIM_DEPTH-1:0] busy;
    logic [VICTIM_DEPTH-1:0] tag_hits;
    logic [VICTIM_DEPTH-1:0] set_hits;
    logic [VICTIM_DEPTH-1:0] key_hits;
    logic [IDX_WIDTH-1:0]    hit_idx;
    logic                    fire_next;

    always_comb begin
        for (int i = 0; i < VICTIM_DEPTH; i++) begin
            slot_tags[i] = slots[i].line.tag;
            slot_sets[i] = slots[i].set;
            busy[i]      = slots[i].line.valid;
        end
    end

    // ----------------------------------------
    // probe, both keys must match
    // ----------------------------------------
    match_cam #(
        .ENTRIES   (VICTIM_DEPTH),
        .KEY_WIDTH ($bits(tag_t))
    ) i_tag_cam (
        .key        (probe_tag),
        .table_keys (slot_tags),
        .hits       (tag_hits)
    );

    match_cam #(
        .ENTRIES   (VICTIM_DEPTH),
        .KEY_WIDTH ($bits(set_t))
    ) i_set_cam (
        .key        (probe_set),
        .table_keys (slot_sets),
        .hits       (set_hits)
    );

    assign key_hits = tag_hits & set_hits & busy;

    // lowest slot wins, that is the youngest copy
    always_comb begin
        hit_idx = '0;
        for (int i = VICTIM_DEPTH - 1; i >= 0; i--) begin
            if (key_hits[i]) begin
                hit_idx = IDX_WIDTH'(i);
            end
        end
    end

    assign probe_hit  = probe_valid && (|key_hits);
    assign probe_line = slots[hit_idx].line;

    // ----------------------------------------
    // reclaim, shift and fire
    // ----------------------------------------
    always_comb begin
        kept = slots;
        if (probe_hit) begin
            kept[hit_idx].line.valid = 1'b0;  // reclaimed slot empties before the shift
        end
        for (int i = 1; i < VICTIM_DEPTH; i++) begin
            slots_next[i] = kept[i-1];
        end
        slots_next[0]            = push_entry;
        slots_next[0].line.valid = push_valid;
        fire_next                = kept[LAST].line.valid;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < VICTIM_DEPTH; i++) begin
                slots[i].line.valid <= 1'b0;
            end
            fired_valid <= 1'b0;
        end else begin
            slots       <= slots_next;
            fired_valid <= fire_next;
        end
    end

    always_ff @(posedge clock) begin
        fired_entry <= slots[LAST];
    end

    // a fired entry was in the last slot and was not taken back that cycle
    a_fire_from_last_slot: assert property (
        @(posedge clock) disable iff (reset)
        fired_valid |-> $past(busy[LAST] && !(probe_hit && (hit_idx == IDX_WIDTH'(LAST))))
    ) else $error("fired entry did not come from an unreclaimed last slot");

endmodule
